/* all.f */
+incdir+verif
src/wb_pkg.sv
src/wb_result_route.sv
src/wb_spr_decode.sv
src/wb_cr_xer_regs.sv
src/wb_link_count_regs.sv
src/wb_gpio_regs.sv
src/wb_stage.sv
verif/wb_stage_tb.sv

/* Bender.yml */
package:
  name: wb_stage

sources:
  - src/wb_pkg.sv
  - src/wb_result_route.sv
  - src/wb_spr_decode.sv
  - src/wb_cr_xer_regs.sv
  - src/wb_link_count_regs.sv
  - src/wb_gpio_regs.sv
  - src/wb_stage.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/wb_stage_tb.sv

/* verif/wb_tb_checks.svh */
`ifndef WB_TB_CHECKS_SVH
`define WB_TB_CHECKS_SVH

// ------------------------------
// random source
// ------------------------------

// galois form, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one lfsr step per bit taken, lsb first
function automatic logic [31:0] take_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v[i]   = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
  end
  return v;
endfunction

// ------------------------------
// compare tasks
// ------------------------------
task automatic stop_on_error(input string msg);
  $display("error @%0t: %s", $time, msg);
  $display("Simulation failed");
  $fatal(1, "result mismatch");
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
  if (got !== exp)
    stop_on_error($sformatf("%s got %h expected %h", name, got, exp));
endtask

task automatic check_cr(input cr_t got, input cr_t exp);
  if (got !== exp)
    stop_on_error($sformatf("cr got %h expected %h", got, exp));
endtask

// write port seen as enable, index and data together
task automatic check_gpr(input logic got_wr, input gpr_idx_t got_sel, input word_t got_data,
                         input logic exp_wr, input gpr_idx_t exp_sel, input word_t exp_data);
  if (got_wr !== exp_wr || got_sel !== exp_sel || got_data !== exp_data)
    stop_on_error($sformatf("gpr port got %b/%0d/%h expected %b/%0d/%h",
                            got_wr, got_sel, got_data, exp_wr, exp_sel, exp_data));
endtask

`endif

/* verif/wb_stage_tb.sv */
`timescale 1ns/1ps

module wb_stage_tb;
  import wb_pkg::*;

  // valid / ov bit handling per row
  localparam logic [1:0] V_RND = 2'd0;
  localparam logic [1:0] V_SET = 2'd1;
  localparam logic [1:0] V_CLR = 2'd2;
  localparam int NUM_ROWS = 26;
  localparam int MAX_CYCLES = 2 * NUM_ROWS + 20;

  typedef enum {CHK_NONE, CHK_CR, CHK_XER, CHK_CTR, CHK_LNK, CHK_SRR0, CHK_SRR1,
                CHK_GOUT, CHK_GOE, CHK_GIN} chk_t;

  // one cycle of channel controls plus the register to look at afterwards
  typedef struct {
    fu_id_t    src;
    fu_id_t    spr_src;
    logic [1:0] vmode;
    logic [1:0] ovmode;
    logic      gpr_we;
    logic      cr_we;
    cr_sel_t   cr_sel;
    logic      xer_we;
    xer_dest_t xer_dest;
    logic      lnk_we;
    logic      ctr_we;
    logic      spr_we;
    spr_t      spr_dest;
    chk_t      chk;
  } row_t;

  logic clk = 1'b0;
  logic reset;
  word_t     [NUM_FU-1:0] fu_res_a, fu_res_b;
  cr_field_t [NUM_FU-1:0] fu_crf;
  logic      [NUM_FU-1:0] fu_cout, fu_ov, fu_valid;
  logic gpr_we, cr_we, xer_we, lnk_we, ctr_we, spr_we;
  fu_id_t gpr_src, cr_src, xer_src, lnk_src, ctr_src, spr_src;
  gpr_idx_t gpr_dest;
  cr_sel_t cr_sel;
  xer_dest_t xer_dest;
  spr_t spr_dest;
  word_t gin_in;
  logic gpr_wr;
  gpr_idx_t gpr_wsel;
  word_t gpr_wdata, xer, ctr, lnk, srr0, srr1, gout, goe, gin;
  cr_t cr;

  row_t rows [NUM_ROWS];
  logic [31:0] lfsr_q = 32'hb8e13498;
  int cycles = 0;

  // reference state
  cr_t m_cr = '0;
  logic m_so = 1'b0;
  logic m_ov = 1'b0;
  logic m_ca = 1'b0;
  word_t m_ctr = '0, m_lnk = '0, m_srr0 = '0, m_srr1 = '0;
  word_t m_gout = '0, m_goe = '0, m_gin = '0;

  `include "wb_tb_checks.svh"

  wb_stage uut (.*);

  always #2 clk = ~clk;

  // hard stop if the table loop stalls
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  task automatic drive_row(input int r);
    logic [NUM_FU-1:0] v;
    logic [NUM_FU-1:0] ov;
    for (int u = 0; u < NUM_FU; u++) begin
      fu_res_a[u] <= word_t'(take_bits(32));
      fu_res_b[u] <= word_t'(take_bits(32));
      fu_crf[u]   <= cr_field_t'(take_bits(4));
    end
    fu_cout <= NUM_FU'(take_bits(NUM_FU));
    v  = NUM_FU'(take_bits(NUM_FU));
    ov = NUM_FU'(take_bits(NUM_FU));
    // forced valid covers both the channel and the spr source
    if (rows[r].vmode == V_SET) begin
      v[rows[r].src]     = 1'b1;
      v[rows[r].spr_src] = 1'b1;
    end else if (rows[r].vmode == V_CLR) begin
      v[rows[r].src]     = 1'b0;
      v[rows[r].spr_src] = 1'b0;
    end
    if (rows[r].ovmode == V_SET) ov[rows[r].src] = 1'b1;
    else if (rows[r].ovmode == V_CLR) ov[rows[r].src] = 1'b0;
    fu_valid <= v;
    fu_ov    <= ov;
    gpr_we   <= rows[r].gpr_we;
    gpr_src  <= rows[r].src;
    gpr_dest <= gpr_idx_t'(take_bits(5));
    cr_we    <= rows[r].cr_we;
    cr_src   <= rows[r].src;
    cr_sel   <= rows[r].cr_sel;
    xer_we   <= rows[r].xer_we;
    xer_src  <= rows[r].src;
    xer_dest <= rows[r].xer_dest;
    lnk_we   <= rows[r].lnk_we;
    lnk_src  <= rows[r].src;
    ctr_we   <= rows[r].ctr_we;
    ctr_src  <= rows[r].src;
    spr_we   <= rows[r].spr_we;
    spr_src  <= rows[r].spr_src;
    spr_dest <= rows[r].spr_dest;
    gin_in   <= word_t'(take_bits(32));
  endtask

  // ------------------------------
  // reference model, one row per call
  // ------------------------------
  task automatic apply_row(input int r);
    fu_id_t s;
    word_t sd;
    logic go;
    logic ok;
    s  = rows[r].src;
    sd = fu_res_a[rows[r].spr_src];
    go = spr_we && fu_valid[rows[r].spr_src];
    ok = fu_valid[s];
    // cr field 0 from the unit crf, others from res_b
    if (cr_we && ok) begin
      for (int i = 0; i < NUM_CR_FIELDS; i++) begin
        if (cr_sel[i]) m_cr[31-4*i -: 4] = (i == 0) ? fu_crf[s] : fu_res_b[s][31-4*i -: 4];
      end
    end
    if (go && spr_dest == SPR_XER) begin
      {m_so, m_ov, m_ca} = sd[31:29];
    end else if (xer_we && ok) begin
      if (xer_dest == XER_ALL) {m_so, m_ov, m_ca} = fu_res_a[s][31:29];
      if (xer_dest == XER_CA || xer_dest == XER_CA_OV) m_ca = fu_cout[s];
      if (xer_dest == XER_OV || xer_dest == XER_CA_OV) begin
        m_ov = fu_ov[s];
        m_so = m_so | fu_ov[s];
      end
    end
    if (go && spr_dest == SPR_CTR) m_ctr = sd;
    else if (ctr_we && ok) m_ctr = fu_res_a[s];
    // branch unit link address rides on res_b
    if (go && spr_dest == SPR_LNK) m_lnk = sd;
    else if (lnk_we && ok) m_lnk = (s == FU_BRANCH) ? fu_res_b[s] : fu_res_a[s];
    if (go && spr_dest == SPR_SRR0) m_srr0 = sd;
    if (go && spr_dest == SPR_SRR1) m_srr1 = sd;
    if (go && spr_dest == SPR_GOUT) m_gout = sd;
    if (go && spr_dest == SPR_GOE) m_goe = sd;
    m_gin = gin_in;
  endtask

  task automatic check_reg(input chk_t c);
    case (c)
      CHK_CR:   check_cr(cr, m_cr);
      CHK_XER:  check_word("xer", xer, {m_so, m_ov, m_ca, 29'd0});
      CHK_CTR:  check_word("ctr", ctr, m_ctr);
      CHK_LNK:  check_word("lnk", lnk, m_lnk);
      CHK_SRR0: check_word("srr0", srr0, m_srr0);
      CHK_SRR1: check_word("srr1", srr1, m_srr1);
      CHK_GOUT: check_word("gout", gout, m_gout);
      CHK_GOE:  check_word("goe", goe, m_goe);
      CHK_GIN:  check_word("gin", gin, m_gin);
      default: ;
    endcase
  endtask

  initial begin
    // src, spr_src, vmode, ovmode, gpr, cr, sel, xer, xdest, lnk, ctr, spr, sdest, chk
    rows[0]  = '{0, 0, V_SET, V_RND, 1, 0, 8'h00, 0, XER_ALL, 0, 0, 0, SPR_NONE, CHK_NONE};
    rows[1]  = '{1, 1, V_CLR, V_RND, 1, 0, 8'h00, 0, XER_ALL, 0, 0, 0, SPR_NONE, CHK_NONE};
    rows[2]  = '{2, 2, V_RND, V_RND, 1, 0, 8'h00, 0, XER_ALL, 0, 0, 0, SPR_NONE, CHK_NONE};
    rows[3]  = '{2, 2, V_SET, V_RND, 0, 1, 8'hff, 0, XER_ALL, 0, 0, 0, SPR_NONE, CHK_CR};
    rows[4]  = '{1, 1, V_SET, V_RND, 0, 1, 8'h05, 0, XER_ALL, 0, 0, 0, SPR_NONE, CHK_CR};
    rows[5]  = '{3, 3, V_SET, V_RND, 0, 1, 8'h80, 0, XER_ALL, 0, 0, 0, SPR_NONE, CHK_CR};
    // invalid source, cr must hold
    rows[6]  = '{0, 0, V_CLR, V_RND, 0, 1, 8'hff, 0, XER_ALL, 0, 0, 0, SPR_NONE, CHK_CR};
    rows[7]  = '{0, 0, V_SET, V_RND, 0, 0, 8'h00, 1, XER_ALL, 0, 0, 0, SPR_NONE, CHK_XER};
    rows[8]  = '{1, 1, V_SET, V_RND, 0, 0, 8'h00, 1, XER_CA, 0, 0, 0, SPR_NONE, CHK_XER};
    rows[9]  = '{2, 2, V_SET, V_SET, 0, 0, 8'h00, 1, XER_OV, 0, 0, 0, SPR_NONE, CHK_XER};
    // ov of zero, so stays up
    rows[10] = '{3, 3, V_SET, V_CLR, 0, 0, 8'h00, 1, XER_OV, 0, 0, 0, SPR_NONE, CHK_XER};
    rows[11] = '{0, 0, V_SET, V_RND, 0, 0, 8'h00, 1, XER_CA_OV, 0, 0, 0, SPR_NONE, CHK_XER};
    rows[12] = '{3, 3, V_SET, V_RND, 0, 0, 8'h00, 0, XER_ALL, 1, 0, 0, SPR_NONE, CHK_LNK};
    rows[13] = '{1, 1, V_SET, V_RND, 0, 0, 8'h00, 0, XER_ALL, 1, 0, 0, SPR_NONE, CHK_LNK};
    rows[14] = '{2, 2, V_SET, V_RND, 0, 0, 8'h00, 0, XER_ALL, 0, 1, 0, SPR_NONE, CHK_CTR};
    // spr move and channel in the same cycle
    rows[15] = '{0, 3, V_SET, V_RND, 0, 0, 8'h00, 0, XER_ALL, 0, 1, 1, SPR_CTR, CHK_CTR};
    rows[16] = '{3, 1, V_SET, V_RND, 0, 0, 8'h00, 0, XER_ALL, 1, 0, 1, SPR_LNK, CHK_LNK};
    rows[17] = '{0, 2, V_SET, V_RND, 0, 0, 8'h00, 0, XER_ALL, 0, 0, 1, SPR_SRR0, CHK_SRR0};
    rows[18] = '{0, 1, V_SET, V_RND, 0, 0, 8'h00, 0, XER_ALL, 0, 0, 1, SPR_SRR1, CHK_SRR1};
    rows[19] = '{0, 3, V_SET, V_RND, 0, 0, 8'h00, 0, XER_ALL, 0, 0, 1, SPR_GOUT, CHK_GOUT};
    rows[20] = '{0, 0, V_SET, V_RND, 0, 0, 8'h00, 0, XER_ALL, 0, 0, 1, SPR_GOE, CHK_GOE};
    rows[21] = '{0, 2, V_SET, V_RND, 0, 0, 8'h00, 0, XER_ALL, 0, 0, 1, SPR_NONE, CHK_GOE};
    rows[22] = '{0, 1, V_SET, V_RND, 0, 0, 8'h00, 0, XER_ALL, 0, 0, 1, SPR_XER, CHK_XER};
    rows[23] = '{0, 0, V_RND, V_RND, 0, 0, 8'h00, 0, XER_ALL, 0, 0, 0, SPR_NONE, CHK_GIN};
    // everything at once, random valid
    rows[24] = '{1, 2, V_RND, V_RND, 1, 1, 8'h5a, 1, XER_CA_OV, 1, 1, 1, SPR_SRR1, CHK_SRR1};
    rows[25] = '{2, 3, V_RND, V_RND, 1, 1, 8'hc3, 1, XER_ALL, 1, 1, 1, SPR_LNK, CHK_LNK};

    fu_res_a = '0;
    fu_res_b = '0;
    fu_crf   = '0;
    fu_cout  = '0;
    fu_ov    = '0;
    fu_valid = '0;
    {gpr_we, cr_we, xer_we, lnk_we, ctr_we, spr_we} = '0;
    {gpr_src, cr_src, xer_src, lnk_src, ctr_src, spr_src} = '0;
    gpr_dest = '0;
    cr_sel   = '0;
    xer_dest = XER_ALL;
    spr_dest = SPR_NONE;
    gin_in   = '0;
    reset    = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // everything cleared by reset
    @(negedge clk);
    check_cr(cr, '0);
    foreach (rows[i]) check_reg(rows[i].chk);
    check_gpr(gpr_wr, gpr_wsel, gpr_wdata, 1'b0, gpr_dest, fu_res_a[gpr_src]);

    for (int r = 0; r < NUM_ROWS; r++) begin
      @(posedge clk);
      drive_row(r);
      @(negedge clk);
      // previous row has landed in the registers by now
      if (r > 0) check_reg(rows[r-1].chk);
      check_gpr(gpr_wr, gpr_wsel, gpr_wdata,
                gpr_we & fu_valid[gpr_src], gpr_dest, fu_res_a[gpr_src]);
      apply_row(r);
    end
    @(posedge clk);
    @(negedge clk);
    check_reg(rows[NUM_ROWS-1].chk);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* src/wb_stage.sv */
`timescale 1ns/1ps

module wb_stage (
  input  logic                                    clk,
  input  logic                                    reset,
  // result bus
  input  wb_pkg::word_t     [wb_pkg::NUM_FU-1:0] fu_res_a,
  input  wb_pkg::word_t     [wb_pkg::NUM_FU-1:0] fu_res_b,
  input  wb_pkg::cr_field_t [wb_pkg::NUM_FU-1:0] fu_crf,
  input  logic              [wb_pkg::NUM_FU-1:0] fu_cout,
  input  logic              [wb_pkg::NUM_FU-1:0] fu_ov,
  input  logic              [wb_pkg::NUM_FU-1:0] fu_valid,
  // channels
  input  logic              gpr_we,
  input  wb_pkg::fu_id_t    gpr_src,
  input  wb_pkg::gpr_idx_t  gpr_dest,
  input  logic              cr_we,
  input  wb_pkg::fu_id_t    cr_src,
  input  wb_pkg::cr_sel_t   cr_sel,
  input  logic              xer_we,
  input  wb_pkg::fu_id_t    xer_src,
  input  wb_pkg::xer_dest_t xer_dest,
  input  logic              lnk_we,
  input  wb_pkg::fu_id_t    lnk_src,
  input  logic              ctr_we,
  input  wb_pkg::fu_id_t    ctr_src,
  input  logic              spr_we,
  input  wb_pkg::fu_id_t    spr_src,
  input  wb_pkg::spr_t      spr_dest,
  input  wb_pkg::word_t     gin_in,
  // gpr write port
  output logic              gpr_wr,
  output wb_pkg::gpr_idx_t  gpr_wsel,
  output wb_pkg::word_t     gpr_wdata,
  // architected registers
  output wb_pkg::cr_t       cr,
  output wb_pkg::word_t     xer,
  output wb_pkg::word_t     ctr,
  output wb_pkg::word_t     lnk,
  output wb_pkg::word_t     srr0,
  output wb_pkg::word_t     srr1,
  output wb_pkg::word_t     gout,
  output wb_pkg::word_t     goe,
  output wb_pkg::word_t     gin
);
  import wb_pkg::*;

  // routed channel writes
  logic      cr_wr, xer_wr, lnk_wr, ctr_wr;
  cr_field_t cr_crf;
  word_t     cr_data, xer_data, lnk_data, ctr_data;
  logic      xer_cout, xer_ov;
  // spr move
  logic      spr_valid;
  word_t     spr_data;
  logic      xer_spr_wr, ctr_spr_wr, lnk_spr_wr;
  logic      srr0_wr, srr1_wr, gout_wr, goe_wr;

  wb_result_route u_route (
    .fu_res_a, .fu_res_b, .fu_crf, .fu_cout, .fu_ov, .fu_valid,
    .gpr_we, .gpr_src, .gpr_dest, .cr_we, .cr_src, .xer_we, .xer_src,
    .lnk_we, .lnk_src, .ctr_we, .ctr_src, .spr_src,
    .gpr_wr, .gpr_wsel, .gpr_wdata, .cr_wr, .cr_crf, .cr_data,
    .xer_wr, .xer_data, .xer_cout, .xer_ov, .lnk_wr, .lnk_data,
    .ctr_wr, .ctr_data, .spr_valid
  );

  wb_spr_decode u_spr (
    .clk, .reset, .spr_we, .spr_src, .spr_dest, .spr_valid, .fu_res_a,
    .spr_data, .xer_spr_wr, .ctr_spr_wr, .lnk_spr_wr,
    .srr0_wr, .srr1_wr, .gout_wr, .goe_wr
  );

  wb_cr_xer_regs u_cr_xer (
    .clk, .reset, .cr_wr, .cr_sel, .cr_crf, .cr_data,
    .xer_wr, .xer_dest, .xer_data, .xer_cout, .xer_ov,
    .xer_spr_wr, .spr_data, .cr, .xer
  );

  wb_link_count_regs u_lnk_ctr (
    .clk, .reset, .ctr_wr, .ctr_data, .lnk_wr, .lnk_data,
    .ctr_spr_wr, .lnk_spr_wr, .srr0_wr, .srr1_wr, .spr_data,
    .ctr, .lnk, .srr0, .srr1
  );

  wb_gpio_regs u_gpio (
    .clk, .reset, .gout_wr, .goe_wr, .spr_data, .gin_in,
    .gout, .goe, .gin
  );

endmodule

/* src/wb_gpio_regs.sv */
`timescale 1ns/1ps

module wb_gpio_regs (
  input  logic          clk,
  input  logic          reset,
  input  logic          gout_wr,
  input  logic          goe_wr,
  input  wb_pkg::word_t spr_data,
  // raw pins
  input  wb_pkg::word_t gin_in,
  output wb_pkg::word_t gout,
  output wb_pkg::word_t goe,
  output wb_pkg::word_t gin
);

  // ------------------------------
  // output value and enable
  // ------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      gout <= '0;
      goe  <= '0;
    end else begin
      if (gout_wr) gout <= spr_data;
      if (goe_wr)  goe  <= spr_data;
    end
  end

  // input sample, one cycle behind the pins
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      gin <= '0;
    end else begin
      gin <= gin_in;
    end
  end

endmodule

/* src/wb_link_count_regs.sv */
`timescale 1ns/1ps

module wb_link_count_regs (
  input  logic          clk,
  input  logic          reset,
  // channel writes
  input  logic          ctr_wr,
  input  wb_pkg::word_t ctr_data,
  input  logic          lnk_wr,
  input  wb_pkg::word_t lnk_data,
  // spr move strobes
  input  logic          ctr_spr_wr,
  input  logic          lnk_spr_wr,
  input  logic          srr0_wr,
  input  logic          srr1_wr,
  input  wb_pkg::word_t spr_data,
  output wb_pkg::word_t ctr,
  output wb_pkg::word_t lnk,
  output wb_pkg::word_t srr0,
  output wb_pkg::word_t srr1
);

  // ------------------------------
  // ctr and lnk, spr move first
  // ------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ctr <= '0;
      lnk <= '0;
    end else begin
      if (ctr_spr_wr) begin
        ctr <= spr_data;
      end else if (ctr_wr) begin
        ctr <= ctr_data;
      end
      // same priority for the link register
      if (lnk_spr_wr) begin
        lnk <= spr_data;
      end else if (lnk_wr) begin
        lnk <= lnk_data;
      end
    end
  end

  // save/restore pair, spr moves only
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      srr0 <= '0;
      srr1 <= '0;
    end else begin
      if (srr0_wr) srr0 <= spr_data;
      if (srr1_wr) srr1 <= spr_data;
    end
  end

endmodule

/* src/wb_cr_xer_regs.sv */
`timescale 1ns/1ps

module wb_cr_xer_regs (
  input  logic              clk,
  input  logic              reset,
  // cr channel
  input  logic              cr_wr,
  input  wb_pkg::cr_sel_t   cr_sel,
  input  wb_pkg::cr_field_t cr_crf,
  input  wb_pkg::word_t     cr_data,
  // xer channel
  input  logic              xer_wr,
  input  wb_pkg::xer_dest_t xer_dest,
  input  wb_pkg::word_t     xer_data,
  input  logic              xer_cout,
  input  logic              xer_ov,
  // spr move
  input  logic              xer_spr_wr,
  input  wb_pkg::word_t     spr_data,
  output wb_pkg::cr_t       cr,
  output wb_pkg::word_t     xer
);
  import wb_pkg::*;

  logic xer_so_q;
  logic xer_ov_q;
  logic xer_ca_q;

  // ------------------------------
  // condition register
  // ------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cr <= '0;
    end else if (cr_wr) begin
      // field 0 from the unit's compare result
      if (cr_sel[0]) begin
        cr[NUM_CR_FIELDS*CR_FIELD_WIDTH-1 -: CR_FIELD_WIDTH] <= cr_crf;
      end
      // fields 1..7 copied from res_b, same position
      for (int i = 1; i < NUM_CR_FIELDS; i++) begin
        if (cr_sel[i]) begin
          cr[(NUM_CR_FIELDS-i)*CR_FIELD_WIDTH-1 -: CR_FIELD_WIDTH] <=
            cr_data[(NUM_CR_FIELDS-i)*CR_FIELD_WIDTH-1 -: CR_FIELD_WIDTH];
        end
      end
    end
  end

  // ------------------------------
  // xer so / ov / ca
  // ------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      xer_so_q <= 1'b0;
      xer_ov_q <= 1'b0;
      xer_ca_q <= 1'b0;
    end else if (xer_spr_wr) begin
      // mtspr overrides the channel, so may clear here
      xer_so_q <= spr_data[XER_SO_BIT];
      xer_ov_q <= spr_data[XER_OV_BIT];
      xer_ca_q <= spr_data[XER_CA_BIT];
    end else if (xer_wr) begin
      case (xer_dest)
        XER_ALL: begin
          xer_so_q <= xer_data[XER_SO_BIT];
          xer_ov_q <= xer_data[XER_OV_BIT];
          xer_ca_q <= xer_data[XER_CA_BIT];
        end
        XER_CA: xer_ca_q <= xer_cout;
        XER_OV: begin
          xer_ov_q <= xer_ov;
          // so is sticky
          xer_so_q <= xer_so_q | xer_ov;
        end
        XER_CA_OV: begin
          xer_ca_q <= xer_cout;
          xer_ov_q <= xer_ov;
          xer_so_q <= xer_so_q | xer_ov;
        end
        default: ;
      endcase
    end
  end

  // reserved bits read zero
  always_comb begin
    xer = '0;
    xer[XER_SO_BIT] = xer_so_q;
    xer[XER_OV_BIT] = xer_ov_q;
    xer[XER_CA_BIT] = xer_ca_q;
  end

  // routed write must come with a defined destination from decode
  a_xer_dest_known: assert property (@(posedge clk) disable iff (reset)
    xer_wr |-> !$isunknown(xer_dest));

endmodule

/* src/wb_spr_decode.sv */
`timescale 1ns/1ps

module wb_spr_decode (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 spr_we,
  input  wb_pkg::fu_id_t                       spr_src,
  input  wb_pkg::spr_t                         spr_dest,
  input  logic                                 spr_valid,
  input  wb_pkg::word_t    [wb_pkg::NUM_FU-1:0] fu_res_a,
  output wb_pkg::word_t                        spr_data,
  output logic                                 xer_spr_wr,
  output logic                                 ctr_spr_wr,
  output logic                                 lnk_spr_wr,
  output logic                                 srr0_wr,
  output logic                                 srr1_wr,
  output logic                                 gout_wr,
  output logic                                 goe_wr
);
  import wb_pkg::*;

  logic spr_go;

  // move data always comes from res_a
  assign spr_data = fu_res_a[spr_src];
  assign spr_go   = spr_we & spr_valid;

  // ------------------------------
  // destination decode
  // ------------------------------
  always_comb begin
    xer_spr_wr = 1'b0;
    ctr_spr_wr = 1'b0;
    lnk_spr_wr = 1'b0;
    srr0_wr    = 1'b0;
    srr1_wr    = 1'b0;
    gout_wr    = 1'b0;
    goe_wr     = 1'b0;
    case (spr_dest)
      SPR_XER:  xer_spr_wr = spr_go;
      SPR_CTR:  ctr_spr_wr = spr_go;
      SPR_LNK:  lnk_spr_wr = spr_go;
      SPR_SRR0: srr0_wr    = spr_go;
      SPR_SRR1: srr1_wr    = spr_go;
      SPR_GOUT: gout_wr    = spr_go;
      SPR_GOE:  goe_wr     = spr_go;
      // spr_none: no register touched
      default: ;
    endcase
  end

  // a move request must name a known source and destination
  a_spr_move_known: assert property (@(posedge clk) disable iff (reset)
    spr_we |-> !$isunknown({spr_src, spr_dest}));

endmodule

/* src/wb_result_route.sv */
`timescale 1ns/1ps

module wb_result_route (
  // result bus
  input  wb_pkg::word_t     [wb_pkg::NUM_FU-1:0] fu_res_a,
  input  wb_pkg::word_t     [wb_pkg::NUM_FU-1:0] fu_res_b,
  input  wb_pkg::cr_field_t [wb_pkg::NUM_FU-1:0] fu_crf,
  input  logic              [wb_pkg::NUM_FU-1:0] fu_cout,
  input  logic              [wb_pkg::NUM_FU-1:0] fu_ov,
  input  logic              [wb_pkg::NUM_FU-1:0] fu_valid,
  // channel controls
  input  logic                gpr_we,
  input  wb_pkg::fu_id_t      gpr_src,
  input  wb_pkg::gpr_idx_t    gpr_dest,
  input  logic                cr_we,
  input  wb_pkg::fu_id_t      cr_src,
  input  logic                xer_we,
  input  wb_pkg::fu_id_t      xer_src,
  input  logic                lnk_we,
  input  wb_pkg::fu_id_t      lnk_src,
  input  logic                ctr_we,
  input  wb_pkg::fu_id_t      ctr_src,
  input  wb_pkg::fu_id_t      spr_src,
  // gpr write port
  output logic                gpr_wr,
  output wb_pkg::gpr_idx_t    gpr_wsel,
  output wb_pkg::word_t       gpr_wdata,
  // to cr / xer block
  output logic                cr_wr,
  output wb_pkg::cr_field_t   cr_crf,
  output wb_pkg::word_t       cr_data,
  output logic                xer_wr,
  output wb_pkg::word_t       xer_data,
  output logic                xer_cout,
  output logic                xer_ov,
  // to ctr / lnk block
  output logic                lnk_wr,
  output wb_pkg::word_t       lnk_data,
  output logic                ctr_wr,
  output wb_pkg::word_t       ctr_data,
  // to spr decode
  output logic                spr_valid
);
  import wb_pkg::*;

  // gpr port, purely combinational
  assign gpr_wr    = gpr_we & fu_valid[gpr_src];
  assign gpr_wsel  = gpr_dest;
  assign gpr_wdata = fu_res_a[gpr_src];

  // cr: field 0 from the unit's crf, rest from res_b
  assign cr_wr   = cr_we & fu_valid[cr_src];
  assign cr_crf  = fu_crf[cr_src];
  assign cr_data = fu_res_b[cr_src];

  // xer channel
  assign xer_wr   = xer_we & fu_valid[xer_src];
  assign xer_data = fu_res_a[xer_src];
  assign xer_cout = fu_cout[xer_src];
  assign xer_ov   = fu_ov[xer_src];

  // branch unit hands the return address on res_b
  assign lnk_wr   = lnk_we & fu_valid[lnk_src];
  assign lnk_data = (lnk_src == FU_BRANCH) ? fu_res_b[FU_BRANCH] : fu_res_a[lnk_src];

  // ctr qualified by its own unit
  assign ctr_wr   = ctr_we & fu_valid[ctr_src];
  assign ctr_data = fu_res_a[ctr_src];

  // spr we is combined in the decoder
  assign spr_valid = fu_valid[spr_src];

endmodule

/* src/wb_pkg.sv */
package wb_pkg;

  // ------------------------------
  // widths
  // ------------------------------

  // data path word
  localparam int WORD_WIDTH = 32;
  // 32 gprs
  localparam int GPR_IDX_WIDTH = 5;
  // lt, gt, eq, so
  localparam int CR_FIELD_WIDTH = 4;
  localparam int NUM_CR_FIELDS = 8;

  // functional units on the result bus
  localparam int NUM_FU = 4;
  localparam int FU_ID_WIDTH = $clog2(NUM_FU);

  // ------------------------------
  // vector types
  // ------------------------------

  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [FU_ID_WIDTH-1:0] fu_id_t;
  typedef logic [GPR_IDX_WIDTH-1:0] gpr_idx_t;
  // bit 3 lt, bit 2 gt, bit 1 eq, bit 0 so
  typedef logic [CR_FIELD_WIDTH-1:0] cr_field_t;
  // field i sits at bits 31-4i downto 28-4i
  typedef logic [NUM_CR_FIELDS*CR_FIELD_WIDTH-1:0] cr_t;
  // bit i selects field i
  typedef logic [NUM_CR_FIELDS-1:0] cr_sel_t;

  // branch unit id, its res_b carries the link address
  localparam fu_id_t FU_BRANCH = 2'd3;

  // xer bit positions, everything below ca reads zero
  localparam int XER_SO_BIT = 31;
  localparam int XER_OV_BIT = 30;
  localparam int XER_CA_BIT = 29;

  // ------------------------------
  // enums
  // ------------------------------

  // which xer bits the xer channel updates
  typedef enum logic [1:0] {
    XER_ALL   = 2'd0,
    XER_CA    = 2'd1,
    XER_OV    = 2'd2,
    XER_CA_OV = 2'd3
  } xer_dest_t;

  // spr move destinations
  typedef enum logic [2:0] {
    SPR_XER  = 3'd0,
    SPR_CTR  = 3'd1,
    SPR_LNK  = 3'd2,
    SPR_SRR0 = 3'd3,
    SPR_SRR1 = 3'd4,
    SPR_GOUT = 3'd5,
    SPR_GOE  = 3'd6,
    SPR_NONE = 3'd7
  } spr_t;

endpackage
